// File: all.f
design/mem_test_pkg.sv
design/sram_bus_pkg.sv
design/mem_pattern_gen.sv
design/mem_fifo.sv
design/striped_sram_ctrl.sv
design/mem_checker.sv
design/mem_test_top.sv
verification/sram_model.sv
verification/mem_test_assertions.sv
verification/mem_test_tb.sv

// File: verification/mem_test_tb.sv
`timescale 1ns/1ps

module mem_test_tb
  import mem_test_pkg::*;
  import sram_bus_pkg::*;
();

  localparam int num_s      = 4;
  localparam int num_bursts = 2;
  localparam int num_beats  = 16;
  localparam int total      = num_bursts * num_beats;
  localparam int rows       = total / num_s;
  localparam int max_cycles = 4 * num_bursts * num_beats * 2 * 4 * 2;

  logic                        clk = 1'b0;
  logic                        rst_n;
  logic                        test_done;
  logic                        test_pass;
  sram_pins_t                  sram_pins [num_s];
  wire [num_s-1:0][data_w-1:0] sram_data;
  logic [data_w-1:0]           snap [num_s][rows];
  int errors = 0;
  int checks = 0;
  int cycles = 0;
  int done_cnt = 0;
  int wr_seen = 0;
  int rd_seen = 0;
  int flip_chip;
  int flip_row;
  int flip_idx;
  bit pass_dropped = 1'b0;
  event snap_ev;
  event flip_ev;

  always #50 clk = ~clk;

  mem_test_top #(.NUM_S(num_s), .NUM_BURSTS(num_bursts), .NUM_BEATS(num_beats)) i_dut (
    .clk(clk), .rst_n(rst_n), .test_done(test_done), .test_pass(test_pass),
    .sram(sram_pins), .sram_data(sram_data)
  );

  for (genvar c = 0; c < num_s; c++) begin : gen_sram
    sram_model #(.DEPTH(rows)) i_sram (
      .addr(sram_pins[c].addr), .ce_n(sram_pins[c].ce_n), .we_n(sram_pins[c].we_n),
      .oe_n(sram_pins[c].oe_n), .data(sram_data[c])
    );
    always @(snap_ev) begin
      for (int r = 0; r < rows; r++) snap[c][r] = i_sram.mem[r];
    end
    always @(flip_ev) begin
      if (flip_chip == c) i_sram.flip_bit(flip_row, flip_idx);
    end
    always @(negedge sram_pins[c].oe_n) begin
      rd_seen++;  // one falling oe_n per read.
    end
  end

  // low word xor 5a5a, rotated left through a doubled copy.
  function automatic logic [data_w-1:0] expected_word(input int addr, input int pass_idx);
    logic [data_w-1:0]   base;
    logic [2*data_w-1:0] twice;
    base  = addr[data_w-1:0] ^ 16'h5A5A;
    twice = {base, base} << (pass_idx % 16);
    return twice[2*data_w-1:data_w];
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0d ns: %s = %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout: the tests did not finish within %0d cycles", max_cycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  always @(negedge clk) begin
    if (rst_n && test_done) done_cnt++;
    if (rst_n && !test_pass) pass_dropped = 1'b1;
  end

  // every write strobe checked against the stripe rule.
  always @(negedge clk) begin : write_monitor
    int chip;
    int lin;
    chip = -1;
    for (int c = 0; c < num_s; c++) begin
      if (!sram_pins[c].ce_n && !sram_pins[c].we_n) chip = c;
    end
    if (rst_n && chip >= 0) begin
      lin = wr_seen % total;
      check("write chip", chip, lin % num_s);
      check("write row", sram_pins[chip].addr, lin / num_s);
      check("write data", sram_data[chip], expected_word(lin, wr_seen / total));
      wr_seen++;
    end
  end

  task automatic wait_done();
    int start;
    start = done_cnt;
    wait (done_cnt > start);
  endtask

  task automatic check_idle();
    for (int c = 0; c < num_s; c++) begin
      check($sformatf("sram[%0d].ce_n", c), sram_pins[c].ce_n, 1'b1);
      check($sformatf("sram[%0d].we_n", c), sram_pins[c].we_n, 1'b1);
      check($sformatf("sram[%0d].oe_n", c), sram_pins[c].oe_n, 1'b1);
    end
    check("test_done", test_done, 1'b0);
    check("test_pass", test_pass, 1'b1);
  endtask

  task automatic reset_state_test();
    repeat (4) @(posedge clk);
    @(negedge clk);
    check_idle();
    @(posedge clk);
    #1 rst_n = 1'b1;
    @(posedge clk);
    @(negedge clk);
    check_idle();
    $display("test 1 reset state finished, %0d errors so far", errors);
  endtask

  task automatic stripe_mapping_test();
    wait (wr_seen >= total);
    $display("test 2 stripe mapping finished, %0d errors so far", errors);
  endtask

  task automatic memory_contents_test();
    -> snap_ev;  // before pass 1 overwrites anything.
    #1;
    wait_done();
    for (int c = 0; c < num_s; c++) begin
      for (int r = 0; r < rows; r++) begin
        check($sformatf("chip %0d row %0d", c, r), snap[c][r], expected_word(r * num_s + c, 0));
      end
    end
    $display("test 3 memory contents finished, %0d errors so far", errors);
  endtask

  task automatic clean_passes_test();
    wait_done();
    wait_done();
    check("test_done count", done_cnt, 3);
    check("reads before third test_done", rd_seen, 3 * total);
    check("test_pass", test_pass, 1'b1);
    check("test_pass dropped", pass_dropped, 1'b0);
    $display("test 4 clean passes finished, %0d errors so far", errors);
  endtask

  task automatic fault_detection_test();
    int target;
    int addr;
    target = (wr_seen / total) * total + num_beats;  // last write of burst 0.
    if (target <= wr_seen) target = target + total;
    wait (wr_seen == target);
    addr      = $urandom_range(num_beats - 1, 0);
    flip_chip = addr % num_s;
    flip_row  = addr / num_s;
    flip_idx  = $urandom_range(data_w - 1, 0);
    -> flip_ev;
    wait_done();
    check("test_pass after fault", test_pass, 1'b0);
    wait_done();
    check("test_pass one pass later", test_pass, 1'b0);
    $display("test 5 fault detection finished, %0d errors so far", errors);
  endtask

  initial begin
    void'($urandom(65));
    rst_n = 1'b0;
    reset_state_test();
    stripe_mapping_test();
    memory_contents_test();
    clean_passes_test();
    fault_detection_test();
    $display("tests 5, checks %0d, errors %0d, writes %0d", checks, errors, wr_seen);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: verification/mem_test_assertions.sv
`timescale 1ns/1ps

module mem_test_assertions
  import sram_bus_pkg::*;
#(
  parameter int NUM_S = 4
) (
  input logic       clk,
  input logic       rst_n,
  input sram_pins_t sram [NUM_S],
  input logic       cmd_pop,
  input logic       cmd_empty
);

  int   ce_low;
  logic strobe_clash;

  always_comb begin
    ce_low       = 0;
    strobe_clash = 1'b0;
    for (int i = 0; i < NUM_S; i++) begin
      ce_low = ce_low + (sram[i].ce_n ? 0 : 1);
      if (!sram[i].we_n && !sram[i].oe_n) begin
        strobe_clash = 1'b1;  // write and read enable together.
      end
    end
  end

  one_chip_selected: assert property (@(posedge clk) disable iff (!rst_n) ce_low <= 1)
    else $error("more than one ce_n low");
  no_strobe_clash: assert property (@(posedge clk) disable iff (!rst_n) !strobe_clash)
    else $error("we_n and oe_n low on the same chip");
  no_pop_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_pop |-> !cmd_empty) else $error("cmd_pop with the command FIFO empty");

endmodule

bind striped_sram_ctrl mem_test_assertions #(
  .NUM_S(NUM_S)
) i_assertions (
  .clk      (clk),
  .rst_n    (rst_n),
  .sram     (sram),
  .cmd_pop  (cmd_pop),
  .cmd_empty(cmd_empty)
);

// File: verification/sram_model.sv
`timescale 1ns/1ps

module sram_model
  import mem_test_pkg::*;
#(
  parameter int DEPTH = 8
) (
  input logic [lin_addr_w-1:0] addr,
  input logic                  ce_n,
  input logic                  we_n,
  input logic                  oe_n,
  inout wire  [data_w-1:0]     data
);

  logic [data_w-1:0] mem [DEPTH];
  logic              in_range;

  assign in_range = addr < DEPTH;

  // async read while selected with oe_n low.
  assign data = (!ce_n && !oe_n && we_n && in_range) ? mem[addr] : 'z;

  always @(negedge we_n) begin
    #1;  // bus settles inside the strobe.
    if (!ce_n && !we_n && in_range) begin
      mem[addr] = data;
    end
  end

  // fault injection.
  task automatic flip_bit(input int row, input int bit_idx);
    mem[row][bit_idx] = ~mem[row][bit_idx];
  endtask

endmodule

// File: design/mem_test_top.sv
`timescale 1ns/1ps

module mem_test_top
  import mem_test_pkg::*;
  import sram_bus_pkg::*;
#(
  parameter int NUM_S      = 4,
  parameter int NUM_BURSTS = 16,
  parameter int NUM_BEATS  = 128,  // bursts times beats must fit in lin_addr_w.
  parameter int FIFO_DEPTH = 8
) (
  input  logic                        clk,
  input  logic                        rst_n,
  output logic                        test_done,
  output logic                        test_pass,
  output sram_pins_t                  sram [NUM_S],
  inout  wire [NUM_S-1:0][data_w-1:0] sram_data
);

  mem_cmd_t cmd_in;
  mem_cmd_t cmd_head;
  logic     cmd_push;
  logic     cmd_pop;
  logic     cmd_full;
  logic     cmd_empty;

  mem_rsp_t rsp_in;
  mem_rsp_t rsp_head;
  logic     rsp_push;
  logic     rsp_pop;
  logic     rsp_full;
  logic     rsp_empty;

  mem_pattern_gen #(
    .NUM_BURSTS(NUM_BURSTS),
    .NUM_BEATS (NUM_BEATS)
  ) i_gen (
    .clk     (clk),
    .rst_n   (rst_n),
    .full    (cmd_full),
    .cmd_push(cmd_push),
    .cmd     (cmd_in)
  );

  mem_fifo #(
    .payload_t(mem_cmd_t),
    .DEPTH    (FIFO_DEPTH)
  ) i_cmd_fifo (
    .clk  (clk),
    .rst_n(rst_n),
    .push (cmd_push),
    .wdata(cmd_in),
    .pop  (cmd_pop),
    .rdata(cmd_head),
    .full (cmd_full),
    .empty(cmd_empty)
  );

  striped_sram_ctrl #(
    .NUM_S(NUM_S)
  ) i_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd      (cmd_head),
    .cmd_empty(cmd_empty),
    .rsp_full (rsp_full),
    .cmd_pop  (cmd_pop),
    .rsp_push (rsp_push),
    .rsp      (rsp_in),
    .sram     (sram),
    .sram_data(sram_data)
  );

  mem_fifo #(
    .payload_t(mem_rsp_t),
    .DEPTH    (FIFO_DEPTH)
  ) i_rsp_fifo (
    .clk  (clk),
    .rst_n(rst_n),
    .push (rsp_push),
    .wdata(rsp_in),
    .pop  (rsp_pop),
    .rdata(rsp_head),
    .full (rsp_full),
    .empty(rsp_empty)
  );

  mem_checker #(
    .NUM_BURSTS(NUM_BURSTS),
    .NUM_BEATS (NUM_BEATS)
  ) i_checker (
    .clk      (clk),
    .rst_n    (rst_n),
    .rsp      (rsp_head),
    .rsp_empty(rsp_empty),
    .rsp_pop  (rsp_pop),
    .test_done(test_done),
    .test_pass(test_pass)
  );

endmodule

// File: design/mem_checker.sv
`timescale 1ns/1ps

module mem_checker
  import mem_test_pkg::*;
#(
  parameter int NUM_BURSTS = 16,
  parameter int NUM_BEATS  = 128
) (
  input  logic     clk,
  input  logic     rst_n,
  input  mem_rsp_t rsp,
  input  logic     rsp_empty,
  output logic     rsp_pop,
  output logic     test_done,
  output logic     test_pass
);

  localparam int total = NUM_BURSTS * NUM_BEATS;
  localparam int cnt_w = (total > 1) ? $clog2(total) : 1;

  logic [cnt_w-1:0] read_cnt;
  logic [7:0]       pass_idx;
  logic             last_read;
  logic             mismatch;

  assign rsp_pop = !rsp_empty;  // drain as results arrive.

  assign last_read = read_cnt == cnt_w'(total - 1);

  // reads come back in linear order, so the count is the expected address.
  assign mismatch = (rsp.data != mem_pattern(rsp.addr, pass_idx)) ||
                    (rsp.addr != lin_addr_w'(read_cnt));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      read_cnt  <= '0;
      pass_idx  <= '0;
      test_done <= 1'b0;
      test_pass <= 1'b1;
    end else begin
      test_done <= rsp_pop && last_read;
      if (rsp_pop) begin
        if (mismatch) begin
          test_pass <= 1'b0;  // sticky.
        end
        if (last_read) begin
          read_cnt <= '0;
          pass_idx <= pass_idx + 1'b1;
        end else begin
          read_cnt <= read_cnt + 1'b1;
        end
      end
    end
  end

endmodule

// File: design/striped_sram_ctrl.sv
`timescale 1ns/1ps

module striped_sram_ctrl
  import mem_test_pkg::*;
  import sram_bus_pkg::*;
#(
  parameter int NUM_S = 4
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  mem_cmd_t                         cmd,
  input  logic                             cmd_empty,
  input  logic                             rsp_full,
  output logic                             cmd_pop,
  output logic                             rsp_push,
  output mem_rsp_t                         rsp,
  output sram_pins_t                       sram [NUM_S],
  inout  wire [NUM_S-1:0][data_w-1:0]      sram_data
);

  localparam int chip_w = $clog2(NUM_S);

  sram_state_e           state;
  logic [chip_w-1:0]     chip_q;
  logic [lin_addr_w-1:0] row_q;
  logic [lin_addr_w-1:0] addr_q;
  logic [data_w-1:0]     data_q;

  // take a command only when its result is sure to fit.
  assign cmd_pop = (state == idle) && !cmd_empty && !rsp_full;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= idle;
    end else begin
      case (state)
        idle: begin
          if (cmd_pop) begin
            state <= cmd.is_write ? write_strobe : read_wait;
          end
        end
        write_strobe: state <= idle;
        read_wait:    state <= read_sample;
        read_sample:  state <= idle;
        default:      state <= idle;
      endcase
    end
  end

  // latch command and decode stripe.
  always_ff @(posedge clk) begin
    if (cmd_pop) begin
      addr_q <= cmd.addr;
      data_q <= cmd.data;
      chip_q <= chip_w'(cmd.addr % NUM_S);  // round robin over chips.
      row_q  <= lin_addr_w'(cmd.addr / NUM_S);
    end
  end

  // bus is sampled at the end of read_sample.
  assign rsp_push  = state == read_sample;
  assign rsp.addr  = addr_q;
  assign rsp.data  = sram_data[chip_q];

  for (genvar i = 0; i < NUM_S; i++) begin : gen_chip
    logic sel;

    assign sel = (state != idle) && (chip_q == chip_w'(i));

    assign sram[i].addr = row_q;
    assign sram[i].ce_n = !sel;
    assign sram[i].we_n = !(sel && state == write_strobe);
    assign sram[i].oe_n = !(sel && (state == read_wait || state == read_sample));

    // drive only the chip being written.
    assign sram_data[i] = (sel && state == write_strobe) ? data_q : 'z;
  end

endmodule

// File: design/mem_fifo.sv
`timescale 1ns/1ps

module mem_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 8
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push,
  input  payload_t wdata,
  input  logic     pop,
  output payload_t rdata,
  output logic     full,
  output logic     empty
);

  localparam int ptr_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int cnt_w = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign full  = count == cnt_w'(DEPTH);
  assign empty = count == '0;
  assign rdata = mem[rd_ptr];  // head is visible before the pop.

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == ptr_w'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == ptr_w'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// File: design/mem_pattern_gen.sv
`timescale 1ns/1ps

module mem_pattern_gen
  import mem_test_pkg::*;
#(
  parameter int NUM_BURSTS = 16,
  parameter int NUM_BEATS  = 128
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     full,
  output logic     cmd_push,
  output mem_cmd_t cmd
);

  localparam int burst_w = (NUM_BURSTS > 1) ? $clog2(NUM_BURSTS) : 1;
  localparam int beat_w  = (NUM_BEATS > 1) ? $clog2(NUM_BEATS) : 1;

  logic [burst_w-1:0]    burst;
  logic [beat_w-1:0]     beat;
  logic                  rd_phase;  // 0 writes, 1 reads back.
  logic [7:0]            pass_idx;
  logic                  running;
  logic                  last_beat;
  logic                  last_burst;
  logic [lin_addr_w-1:0] lin_addr;

  assign last_beat  = beat == beat_w'(NUM_BEATS - 1);
  assign last_burst = burst == burst_w'(NUM_BURSTS - 1);

  assign lin_addr = lin_addr_w'(burst) * lin_addr_w'(NUM_BEATS) + lin_addr_w'(beat);

  // push whenever there is room.
  assign cmd_push = running && !full;

  always_comb begin
    cmd.is_write = !rd_phase;
    cmd.addr     = lin_addr;
    cmd.data     = rd_phase ? '0 : mem_pattern(lin_addr, pass_idx);
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      running <= 1'b0;
    end else begin
      running <= 1'b1;  // start one cycle out of reset.
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      burst    <= '0;
      beat     <= '0;
      rd_phase <= 1'b0;
      pass_idx <= '0;
    end else if (cmd_push) begin
      if (!last_beat) begin
        beat <= beat + 1'b1;
      end else begin
        beat <= '0;
        if (!rd_phase) begin
          rd_phase <= 1'b1;  // same beats again, as reads.
        end else begin
          rd_phase <= 1'b0;
          if (last_burst) begin
            burst    <= '0;
            pass_idx <= pass_idx + 1'b1;
          end else begin
            burst <= burst + 1'b1;
          end
        end
      end
    end
  end

endmodule

// File: design/sram_bus_pkg.sv
package sram_bus_pkg;

  import mem_test_pkg::*;

  // pins of one async SRAM chip with active low strobes.
  typedef struct packed {
    logic [lin_addr_w-1:0] addr;  // row within the chip.
    logic                  we_n;
    logic                  oe_n;
    logic                  ce_n;
  } sram_pins_t;

  // controller sequencing.
  typedef enum logic [1:0] {
    idle,
    write_strobe,
    read_wait,
    read_sample
  } sram_state_e;

endpackage

// File: design/mem_test_pkg.sv
package mem_test_pkg;

  localparam int lin_addr_w = 18;
  localparam int data_w     = 16;

  // one entry of the command FIFO.
  typedef struct packed {
    logic                  is_write;
    logic [lin_addr_w-1:0] addr;
    logic [data_w-1:0]     data;
  } mem_cmd_t;

  // read result with its address for checking.
  typedef struct packed {
    logic [lin_addr_w-1:0] addr;
    logic [data_w-1:0]     data;
  } mem_rsp_t;

  // low address bits xor 5a5a, rotated left by the pass index.
  function automatic logic [data_w-1:0] mem_pattern(input logic [lin_addr_w-1:0] addr,
                                                    input logic [7:0] pass_idx);
    logic [data_w-1:0] base;
    logic [3:0]        rot;
    base = addr[data_w-1:0] ^ 16'h5A5A;
    rot  = pass_idx[3:0];  // modulo 16.
    return (base << rot) | (base >> (5'd16 - {1'b0, rot}));
  endfunction

endpackage
